// File: unpack_pkg.sv
package unpack_pkg;

   // width of the field-width value, enough for widths up to 32
   localparam int cfg_w_c = 6;

   // unpacker configuration, held steady from reset on
   typedef struct packed {
      // wrap mode, whole fields per word
      logic               wrap;
      // field width in bits
      logic [cfg_w_c-1:0] width;
   } unpack_cfg_t;

   // default top-level sizes
   localparam int def_data_w_c    = 21;
   localparam int def_in_depth_c  = 4;
   localparam int def_out_depth_c = 4;

endpackage

// File: stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo import unpack_pkg::*; #(
   parameter int DATA_W = def_data_w_c,
   parameter int DEPTH  = def_in_depth_c
) (
   input  logic              clk_i,
   input  logic              rst_i,

   // write side
   input  logic              wr_valid_i,
   input  logic [DATA_W-1:0] wr_data_i,
   output logic              wr_ready_o,

   // read side
   output logic              rd_valid_o,
   output logic [DATA_W-1:0] rd_data_o,
   input  logic              rd_ready_i
);

   localparam int ptr_w_c = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int cnt_w_c = $clog2(DEPTH + 1);
   localparam logic [ptr_w_c-1:0] last_ptr_c = ptr_w_c'(DEPTH - 1);
   localparam logic [cnt_w_c-1:0] full_cnt_c = cnt_w_c'(DEPTH);

   logic [DATA_W-1:0]  mem_q [DEPTH];
   logic [ptr_w_c-1:0] wr_ptr_q;
   logic [ptr_w_c-1:0] rd_ptr_q;
   logic [cnt_w_c-1:0] count_q;
   logic               rd_valid_q;
   logic [DATA_W-1:0]  rd_data_q;
   logic               wr_en;
   logic               load;

   function automatic logic [ptr_w_c-1:0] next_ptr(input logic [ptr_w_c-1:0] ptr);
      return (ptr == last_ptr_c) ? '0 : ptr + 1'b1;
   endfunction

   assign wr_ready_o = (count_q != full_cnt_c);
   assign wr_en      = wr_valid_i && wr_ready_o;
   // refill output register when it is empty or being drained
   assign load       = (count_q != '0) && (!rd_valid_q || rd_ready_i);

   assign rd_valid_o = rd_valid_q;
   assign rd_data_o  = rd_data_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (load) begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         case ({wr_en, load})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         if (load) begin
            rd_valid_q <= 1'b1;
         end else if (rd_ready_i) begin
            rd_valid_q <= 1'b0;
         end
      end
   end

   // storage and output data
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem_q[wr_ptr_q] <= wr_data_i;
      end
      if (load) begin
         rd_data_q <= mem_q[rd_ptr_q];
      end
   end

   // pointers meet only when empty or full
   a_ptr_count: assert property (@(posedge clk_i) disable iff (rst_i)
      (wr_ptr_q == rd_ptr_q) == ((count_q == '0) || (count_q == full_cnt_c)))
      else $error("stream_fifo pointers and count disagree");

   // an offered word stays until it is taken
   a_rd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o))
      else $error("stream_fifo output dropped before transfer");

endmodule

// File: bit_fifo.sv
`timescale 1ns/1ps

module bit_fifo import unpack_pkg::*; #(
   parameter int DATA_W = def_data_w_c
) (
   input  logic               clk_i,
   input  logic               rst_i,

   // push the top push_width_i bits of a word
   input  logic               push_i,
   input  logic [cfg_w_c-1:0] push_width_i,
   input  logic [DATA_W-1:0]  push_data_i,

   // pop the oldest pop_width_i bits
   input  logic               pop_i,
   input  logic [cfg_w_c-1:0] pop_width_i,
   output logic [DATA_W-1:0]  pop_data_o,

   // levels in bits
   output logic [cfg_w_c:0]   free_level_o,
   output logic [cfg_w_c:0]   fill_level_o
);

   localparam int buf_w_c = 2 * DATA_W;
   localparam logic [cfg_w_c:0] buf_lvl_c = (cfg_w_c + 1)'(buf_w_c);

   // oldest bit at the msb, bits below the fill level kept at zero
   logic [buf_w_c-1:0] buf_q;
   logic [buf_w_c-1:0] buf_popped;
   logic [buf_w_c-1:0] buf_nxt;
   logic [buf_w_c-1:0] push_bits;
   logic [buf_w_c-1:0] pop_view;
   logic [cfg_w_c:0]   fill_q;
   logic [cfg_w_c:0]   fill_popped;
   logic [cfg_w_c:0]   fill_nxt;

   assign fill_level_o = fill_q;
   assign free_level_o = buf_lvl_c - fill_q;

   // oldest bits, right-aligned with zeros above
   assign pop_view   = buf_q >> (buf_w_c - int'(pop_width_i));
   assign pop_data_o = pop_view[DATA_W-1:0];

   always_comb begin
      buf_popped  = buf_q;
      fill_popped = fill_q;
      if (pop_i) begin
         buf_popped  = buf_q << pop_width_i;
         fill_popped = fill_q - {1'b0, pop_width_i};
      end

      // keep only the top push_width_i bits of the word
      push_bits = {push_data_i, {DATA_W{1'b0}}} & ~({buf_w_c{1'b1}} >> push_width_i);

      buf_nxt  = buf_popped;
      fill_nxt = fill_popped;
      if (push_i) begin
         // append right behind the remaining bits
         buf_nxt  = buf_popped | (push_bits >> fill_popped);
         fill_nxt = fill_popped + {1'b0, push_width_i};
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         buf_q  <= '0;
         fill_q <= '0;
      end else begin
         buf_q  <= buf_nxt;
         fill_q <= fill_nxt;
      end
   end

   // the controller must check room before pushing
   a_push_fits: assert property (@(posedge clk_i) disable iff (rst_i)
      push_i |-> {1'b0, push_width_i} <= free_level_o)
      else $error("bit_fifo push beyond free level");

   // and enough bits before popping
   a_pop_fits: assert property (@(posedge clk_i) disable iff (rst_i)
      pop_i |-> {1'b0, pop_width_i} <= fill_level_o)
      else $error("bit_fifo pop beyond fill level");

endmodule

// File: field_unpacker.sv
`timescale 1ns/1ps

module field_unpacker import unpack_pkg::*; #(
   parameter int DATA_W = def_data_w_c
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  unpack_cfg_t       cfg_i,

   // packed words in
   input  logic              word_valid_i,
   input  logic [DATA_W-1:0] word_data_i,
   output logic              word_ready_o,

   // fields out
   output logic              field_valid_o,
   output logic [DATA_W-1:0] field_data_o,
   input  logic              field_ready_i
);

   // state counter values
   localparam logic [1:0] st_cfg_c  = 2'd0;
   localparam logic [1:0] st_read_c = 2'd1;
   localparam logic [1:0] st_push_c = 2'd2;
   localparam logic [1:0] st_pop_c  = 2'd3;

   localparam logic [cfg_w_c-1:0] data_w_c = cfg_w_c'(DATA_W);

   logic [1:0]         pcnt_q;
   logic [1:0]         pcnt_nxt;
   logic [cfg_w_c-1:0] wrap_acc_q;
   logic [cfg_w_c-1:0] wrap_acc_nxt;
   logic [cfg_w_c-1:0] push_width;
   logic [cfg_w_c:0]   acc_sum;
   logic [cfg_w_c:0]   free_level;
   logic [cfg_w_c:0]   fill_level;
   logic [DATA_W-1:0]  word_q;
   logic               push;
   logic               pop;

   // wrap mode pushes only whole fields
   assign push_width = cfg_i.wrap ? wrap_acc_q : data_w_c;
   assign acc_sum    = {1'b0, wrap_acc_q} + {1'b0, cfg_i.width};

   assign word_ready_o  = (pcnt_q == st_read_c) && (free_level >= {1'b0, push_width});
   assign field_valid_o = (pcnt_q == st_pop_c) && (fill_level >= {1'b0, cfg_i.width});
   assign push          = (pcnt_q == st_push_c);
   assign pop           = field_valid_o && field_ready_i;

   always_comb begin
      pcnt_nxt     = pcnt_q + 2'd1;
      wrap_acc_nxt = wrap_acc_q;
      case (pcnt_q)
         st_cfg_c: begin
            // one field per cycle until the next would not fit
            if (cfg_i.wrap && (acc_sum <= {1'b0, data_w_c})) begin
               pcnt_nxt     = st_cfg_c;
               wrap_acc_nxt = acc_sum[cfg_w_c-1:0];
            end
         end
         st_read_c: begin
            if (!(word_valid_i && word_ready_o)) begin
               pcnt_nxt = st_pop_c;
            end
         end
         st_push_c: begin
            pcnt_nxt = st_pop_c;
         end
         default: begin
            // hold an offered field until the output side takes it
            if (field_valid_o && !field_ready_i) begin
               pcnt_nxt = st_pop_c;
            end else begin
               pcnt_nxt = st_read_c;
            end
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pcnt_q     <= st_cfg_c;
         wrap_acc_q <= '0;
      end else begin
         pcnt_q     <= pcnt_nxt;
         wrap_acc_q <= wrap_acc_nxt;
      end
   end

   // word held for the push state
   always_ff @(posedge clk_i) begin
      if (word_valid_i && word_ready_o) begin
         word_q <= word_data_i;
      end
   end

   bit_fifo #(
      .DATA_W(DATA_W)
   ) bfifo (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .push_i      (push),
      .push_width_i(push_width),
      .push_data_i (word_q),
      .pop_i       (pop),
      .pop_width_i (cfg_i.width),
      .pop_data_o  (field_data_o),
      .free_level_o(free_level),
      .fill_level_o(fill_level)
   );

   // field width from the top level must fit a word
   a_cfg_width: assert property (@(posedge clk_i) disable iff (rst_i)
      (cfg_i.width != '0) && (cfg_i.width <= data_w_c))
      else $error("field width out of range");

endmodule

// File: unpack_top.sv
`timescale 1ns/1ps

module unpack_top import unpack_pkg::*; #(
   parameter int DATA_W    = def_data_w_c,
   parameter int IN_DEPTH  = def_in_depth_c,
   parameter int OUT_DEPTH = def_out_depth_c
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  unpack_cfg_t       cfg_i,

   // packed words
   input  logic              in_valid_i,
   output logic              in_ready_o,
   input  logic [DATA_W-1:0] in_data_i,

   // unpacked fields
   output logic              out_valid_o,
   input  logic              out_ready_i,
   output logic [DATA_W-1:0] out_data_o
);

   logic              word_valid;
   logic              word_ready;
   logic [DATA_W-1:0] word_data;
   logic              field_valid;
   logic              field_ready;
   logic [DATA_W-1:0] field_data;

   // input side
   stream_fifo #(
      .DATA_W(DATA_W),
      .DEPTH (IN_DEPTH)
   ) in_fifo (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_valid_i(in_valid_i),
      .wr_data_i (in_data_i),
      .wr_ready_o(in_ready_o),
      .rd_valid_o(word_valid),
      .rd_data_o (word_data),
      .rd_ready_i(word_ready)
   );

   field_unpacker #(
      .DATA_W(DATA_W)
   ) unpacker (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .cfg_i        (cfg_i),
      .word_valid_i (word_valid),
      .word_data_i  (word_data),
      .word_ready_o (word_ready),
      .field_valid_o(field_valid),
      .field_data_o (field_data),
      .field_ready_i(field_ready)
   );

   // output side
   stream_fifo #(
      .DATA_W(DATA_W),
      .DEPTH (OUT_DEPTH)
   ) out_fifo (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .wr_valid_i(field_valid),
      .wr_data_i (field_data),
      .wr_ready_o(field_ready),
      .rd_valid_o(out_valid_o),
      .rd_data_o (out_data_o),
      .rd_ready_i(out_ready_i)
   );

endmodule

// File: tb_unpack.sv
`timescale 1ns/1ps

module tb_unpack import unpack_pkg::*; ();

   localparam int data_w_c = 21;
   // about 300 words, 8 cycles each, 5x margin for stalls
   localparam int max_cycles_c = 12000;

   logic                clk_i = 1'b0;
   logic                rst_i = 1'b1;
   unpack_cfg_t         cfg_i;
   logic                in_valid_i;
   logic                in_ready_o;
   logic [data_w_c-1:0] in_data_i;
   logic                out_valid_o;
   logic                out_ready_i;
   logic [data_w_c-1:0] out_data_o;

   // 0 always ready, 1 random, 2 held low
   int          out_mode;
   logic [31:0] rng_in;
   logic [31:0] rng_out;

   // reference bitstream, oldest bit first
   bit                  exp_bits[$];
   logic [data_w_c-1:0] exp_field;
   bit                  exp_avail;
   int                  acc_bits;
   int                  out_cnt;

   unpack_top #(
      .DATA_W(data_w_c)
   ) dut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cfg_i      (cfg_i),
      .in_valid_i (in_valid_i),
      .in_ready_o (in_ready_o),
      .in_data_i  (in_data_i),
      .out_valid_o(out_valid_o),
      .out_ready_i(out_ready_i),
      .out_data_o (out_data_o)
   );

   task automatic stop_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic plain_error(input string what);
      $display("error: %s", what);
      stop_run();
   endtask

   task automatic value_error(input string name, input logic [31:0] expv,
                              input logic [31:0] gotv);
      $display("FAILED %s expected %h got %h", name, expv, gotv);
      stop_run();
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // wrap mode keeps only whole fields of each word
   function automatic int kept_bits(input logic wrap, input int fw);
      if (wrap) begin
         return (data_w_c / fw) * fw;
      end
      return data_w_c;
   endfunction

   initial begin : clock_gen
      forever #50 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin : out_driver
      #1;
      rng_out = xorshift32(rng_out);
      case (out_mode)
         0:       out_ready_i = 1'b1;
         1:       out_ready_i = rng_out[7];
         default: out_ready_i = 1'b0;
      endcase
   end

   // handshakes are settled at the falling edge before the transfer
   always @(negedge clk_i) begin : ref_model
      int fw;
      int keep;
      int i;
      fw   = int'(cfg_i.width);
      keep = kept_bits(cfg_i.wrap, fw);
      if (rst_i) begin
         exp_bits.delete();
         acc_bits = 0;
         out_cnt  = 0;
      end else begin
         if (out_valid_o && out_ready_i) begin
            for (i = 0; i < fw && exp_bits.size() > 0; i++) begin
               void'(exp_bits.pop_front());
            end
            out_cnt++;
         end
         if (in_valid_i && in_ready_o) begin
            for (i = 0; i < keep; i++) begin
               exp_bits.push_back(in_data_i[data_w_c-1-i]);
            end
            acc_bits += keep;
         end
      end
      exp_avail = (exp_bits.size() >= fw);
      exp_field = '0;
      for (i = 0; exp_avail && i < fw; i++) begin
         exp_field = {exp_field[data_w_c-2:0], exp_bits[i]};
      end
   end

   a_reset_state: assert property (@(negedge clk_i)
      $fell(rst_i) |-> !out_valid_o && in_ready_o)
      else plain_error("outputs not idle right after reset");

   a_no_extra: assert property (@(negedge clk_i) disable iff (rst_i)
      out_valid_o |-> exp_avail)
      else plain_error("output field without enough input bits behind it");

   a_field_value: assert property (@(negedge clk_i) disable iff (rst_i)
      out_valid_o && exp_avail |-> out_data_o == exp_field)
      else value_error("out_data_o", $sampled(exp_field), $sampled(out_data_o));

   a_out_hold: assert property (@(negedge clk_i) disable iff (rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
      else plain_error("output field changed or dropped before its transfer");

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < max_cycles_c) begin
         @(posedge clk_i);
         cycles++;
      end
      plain_error("run did not finish within the cycle limit");
   end

   task automatic apply_reset(input logic wrap, input int fw);
      @(posedge clk_i);
      #1;
      rst_i       = 1'b1;
      in_valid_i  = 1'b0;
      cfg_i.wrap  = wrap;
      cfg_i.width = cfg_w_c'(fw);
      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
   endtask

   // returns 1 ns after the edge that takes the offered word
   task automatic wait_accept();
      @(negedge clk_i);
      while (!in_ready_o) begin
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
   endtask

   task automatic send_words(input int count, input int stall_pct);
      int sent;
      sent = 0;
      while (sent < count) begin
         rng_in = xorshift32(rng_in);
         if ((rng_in % 100) < stall_pct) begin
            in_valid_i = 1'b0;
            @(posedge clk_i);
            #1;
         end else begin
            rng_in     = xorshift32(rng_in);
            in_valid_i = 1'b1;
            in_data_i  = rng_in[data_w_c-1:0];
            wait_accept();
            sent++;
         end
      end
      in_valid_i = 1'b0;
   endtask

   // keeps offering words until the input side stops taking them
   task automatic hold_back_pressure(input int limit);
      int sent;
      int stalled;
      sent       = 0;
      stalled    = 0;
      rng_in     = xorshift32(rng_in);
      in_valid_i = 1'b1;
      in_data_i  = rng_in[data_w_c-1:0];
      while (stalled < 30 && sent < limit) begin
         @(negedge clk_i);
         if (in_ready_o) begin
            @(posedge clk_i);
            #1;
            sent++;
            stalled   = 0;
            rng_in    = xorshift32(rng_in);
            in_data_i = rng_in[data_w_c-1:0];
         end else begin
            stalled++;
         end
      end
      assert (stalled >= 30)
         else plain_error("in_ready_o stayed high while out_ready_i was held low");
   endtask

   // model state settles at the falling edge, so look at the rising edge
   task automatic wait_drain();
      @(posedge clk_i);
      while (exp_bits.size() >= int'(cfg_i.width)) begin
         @(posedge clk_i);
      end
      // idle cycles so a stray extra field shows up
      repeat (12) @(posedge clk_i);
      assert (out_cnt == acc_bits / int'(cfg_i.width))
         else value_error("field count", acc_bits / int'(cfg_i.width), out_cnt);
   endtask

   task automatic run_phase(input logic wrap, input int fw, input int count,
                            input int stall_pct, input int mode);
      out_mode = mode;
      apply_reset(wrap, fw);
      send_words(count, stall_pct);
      wait_drain();
   endtask

   initial begin : main_seq
      cfg_i.wrap  = 1'b0;
      cfg_i.width = cfg_w_c'(5);
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      out_mode    = 0;
      rng_in      = 32'd87456;
      rng_out     = ~32'd87456;
      // fields straddle word boundaries
      run_phase(1'b0, 5, 60, 0, 0);
      // low bit of each word dropped
      run_phase(1'b1, 4, 60, 0, 0);
      // random stalls on both sides
      run_phase(1'b0, 7, 80, 30, 1);
      run_phase(1'b1, 6, 60, 30, 1);
      // one field per word
      run_phase(1'b0, data_w_c, 30, 20, 1);
      // back-pressure through every stage
      out_mode = 2;
      apply_reset(1'b0, 5);
      hold_back_pressure(40);
      out_mode = 0;
      wait_accept();
      in_valid_i = 1'b0;
      wait_drain();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: flist.f
unpack_pkg.sv
stream_fifo.sv
bit_fifo.sv
field_unpacker.sv
unpack_top.sv
tb_unpack.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the unpacker testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_unpack \
   -f flist.f -o tb_unpack_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_unpack_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
   echo "simulation reported a failure"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "simulation finished without failure"
exit 0
